// File: common/qla_pkg.sv
// --------------------
// shared types and constants for the motor command path
// bus words, address fields, register offsets, DAC framing
// --------------------

package qla_pkg;

    // --------------------
    // widths and defaults
    // --------------------
    localparam int FIELD_W = 4;             // area, channel and offset nibbles
    localparam int DATA_W  = 32;            // register data word
    localparam int CMD_W   = 16;            // dac code
    localparam int DAC_FRAME_W = 24;        // cmd nibble + chan nibble + code

    localparam int DEF_NUM_CHAN     = 4;    // axes on the qla
    localparam int DEF_DAC_CLK_DIV  = 2;    // sysclk cycles per sclk half period
    localparam int DEF_SAFETY_LIMIT = 16;   // bad samples before amp disable

    // --------------------
    // basic words
    // --------------------
    // 15..12 area, 11..8 unused, 7..4 channel, 3..0 offset
    typedef struct packed {
        logic [FIELD_W-1:0] area;
        logic [FIELD_W-1:0] rsvd;
        logic [FIELD_W-1:0] chan;
        logic [FIELD_W-1:0] off;
    } addr_t;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [CMD_W-1:0]  cmd_t;       // offset binary, mid-scale = 0 A

    // address map, main area only
    localparam logic [FIELD_W-1:0] ADDR_MAIN        = 4'd0;
    localparam logic [FIELD_W-1:0] OFF_ADC_DATA     = 4'd0;
    localparam logic [FIELD_W-1:0] OFF_DAC_CTRL     = 4'd1;
    localparam logic [FIELD_W-1:0] OFF_MOTOR_STATUS = 4'd12;

    localparam cmd_t CMD_RESET = 16'h8000;                 // zero current
    localparam logic [3:0] DAC_CMD_WRITE_UPDATE = 4'b0011; // write + update dac n
    localparam logic [CMD_W-1:0] SAFETY_MARGIN = 16'h0100;

    // --------------------
    // write bus structs
    // --------------------
    // host link side, full address
    typedef struct packed {
        logic  wen;
        logic  blk_wen;     // end of block write, requests dac refresh
        addr_t waddr;
        data_t wdata;
    } host_wr_t;

    // real-time block writer, channel and offset only
    typedef struct packed {
        logic       active;     // owns the write bus while high
        logic       wen;
        logic       blk_wen;
        logic [7:0] waddr;      // chan in 7..4, offset in 3..0
        data_t      wdata;
    } rt_wr_t;

    // bus after the host/rt mux
    typedef struct packed {
        logic  wen;
        logic  blk_wen;
        addr_t waddr;
        data_t wdata;
    } wr_bus_t;

endpackage

// File: logic/bus_ctrl.sv
// --------------------
// write bus select, command write decode and main area readback
// --------------------

module bus_ctrl import qla_pkg::*; #(
    parameter int NUM_CHAN = DEF_NUM_CHAN
) (
    input  host_wr_t              host_wr,
    input  rt_wr_t                rt_wr,
    output wr_bus_t               wr_bus,
    input  addr_t                 raddr,
    output data_t                 rdata,
    output logic                  cmd_we,       // store command
    output logic                  cmd_req,      // request dac refresh
    output logic [3:0]            cmd_chan,
    input  cmd_t [1:NUM_CHAN]     cur_cmd,
    input  cmd_t [1:NUM_CHAN]     cur_fb,
    input  logic [NUM_CHAN:1]     amp_disable
);

    localparam logic [3:0] MAX_CHAN = 4'(NUM_CHAN);

    logic   wr_dac;         // write hits a command register
    logic   rd_hit;         // read chan in 1..NUM_CHAN
    cmd_t   rd_cmd;
    cmd_t   rd_fb;
    logic   rd_dis;

    // --------------------
    // write side
    // --------------------
    always_comb begin
        if (rt_wr.active) begin
            // rt writer carries chan and offset only so main area is implied
            wr_bus.wen     = rt_wr.wen;
            wr_bus.blk_wen = rt_wr.blk_wen;
            wr_bus.waddr   = addr_t'({ADDR_MAIN, 4'd0, rt_wr.waddr});
            wr_bus.wdata   = rt_wr.wdata;
        end else begin
            wr_bus.wen     = host_wr.wen;
            wr_bus.blk_wen = host_wr.blk_wen;
            wr_bus.waddr   = host_wr.waddr;
            wr_bus.wdata   = host_wr.wdata;
        end
    end

    // chan 0 is board space and nothing sits above NUM_CHAN
    assign wr_dac = (wr_bus.waddr.area == ADDR_MAIN) &&
                    (wr_bus.waddr.chan != 4'd0) &&
                    (wr_bus.waddr.chan <= MAX_CHAN) &&
                    (wr_bus.waddr.off == OFF_DAC_CTRL);

    assign cmd_we   = wr_dac & wr_bus.wen;
    assign cmd_req  = wr_dac & wr_bus.blk_wen;
    assign cmd_chan = wr_bus.waddr.chan;

    // --------------------
    // read side
    // --------------------
    always_comb begin
        rd_hit = 1'b0;
        rd_cmd = '0;
        rd_fb  = '0;
        rd_dis = 1'b0;
        for (int i = 1; i <= NUM_CHAN; i++) begin
            if (raddr.chan == 4'(i)) begin
                rd_hit = 1'b1;
                rd_cmd = cur_cmd[i];
                rd_fb  = cur_fb[i];
                rd_dis = amp_disable[i];
            end
        end

        rdata = '0;                                     // unmapped reads as zero
        if (raddr.area == ADDR_MAIN && rd_hit) begin
            case (raddr.off)
                OFF_ADC_DATA:     rdata = {16'd0, rd_fb};
                OFF_DAC_CTRL:     rdata = {16'd0, rd_cmd};
                OFF_MOTOR_STATUS: rdata = {3'b000, ~rd_dis, 12'd0, rd_cmd}; // 28 = amp on
                default:          rdata = '0;
            endcase
        end
    end

endmodule

// File: logic/qla_motor_ctrl.sv
// --------------------
// qla motor command path, top level
// --------------------

module qla_motor_ctrl import qla_pkg::*; #(
    parameter int NUM_CHAN     = DEF_NUM_CHAN,
    parameter int DAC_CLK_DIV  = DEF_DAC_CLK_DIV,
    parameter int SAFETY_LIMIT = DEF_SAFETY_LIMIT
) (
    input  logic                  sysclk,
    input  logic                  arst_n,
    input  host_wr_t              host_wr,          // host link write port
    input  rt_wr_t                rt_wr,            // real-time block writer
    input  addr_t                 raddr,
    output data_t                 rdata,
    input  cmd_t [1:NUM_CHAN]     cur_fb,           // current feedback words
    input  logic                  pwr_enable_cmd,
    input  logic [NUM_CHAN:1]     amp_enable_cmd,
    output logic                  dac_sclk,
    output logic                  dac_mosi,
    output logic                  dac_csel,
    output logic [NUM_CHAN:1]     amp_disable
);

    wr_bus_t               wr_bus;      // selected write bus
    logic                  cmd_we;
    logic                  cmd_req;
    logic [3:0]            cmd_chan;
    cmd_t [1:NUM_CHAN]     cur_cmd;
    logic                  dac_busy;
    logic                  dac_update;

    bus_ctrl #(.NUM_CHAN(NUM_CHAN)) u_bus_ctrl (
        .host_wr(host_wr), .rt_wr(rt_wr), .wr_bus(wr_bus),
        .raddr(raddr), .rdata(rdata),
        .cmd_we(cmd_we), .cmd_req(cmd_req), .cmd_chan(cmd_chan),
        .cur_cmd(cur_cmd), .cur_fb(cur_fb), .amp_disable(amp_disable)
    );

    cur_cmd_regs #(.NUM_CHAN(NUM_CHAN)) u_cur_cmd_regs (
        .sysclk(sysclk), .arst_n(arst_n),
        .cmd_we(cmd_we), .cmd_req(cmd_req), .cmd_chan(cmd_chan),
        .wdata(wr_bus.wdata[15:0]),     // low half carries the code
        .dac_busy(dac_busy), .cur_cmd(cur_cmd), .dac_update(dac_update)
    );

    dac_serializer #(.NUM_CHAN(NUM_CHAN), .DAC_CLK_DIV(DAC_CLK_DIV)) u_dac (
        .sysclk(sysclk), .arst_n(arst_n),
        .dac_update(dac_update), .cur_cmd(cur_cmd), .busy(dac_busy),
        .sclk(dac_sclk), .mosi(dac_mosi), .csel(dac_csel)
    );

    // one overcurrent check per axis
    for (genvar i = 1; i <= NUM_CHAN; i++) begin : g_safe
        safety_check #(.SAFETY_LIMIT(SAFETY_LIMIT)) u_safe (
            .sysclk(sysclk), .arst_n(arst_n),
            .cur_fb(cur_fb[i]), .cur_cmd(cur_cmd[i]),
            .clear(pwr_enable_cmd | amp_enable_cmd[i]),    // either enable clears
            .amp_disable(amp_disable[i])
        );
    end

endmodule

// File: motor/cur_cmd_regs.sv
// --------------------
// commanded-current registers and dac refresh request
// --------------------

module cur_cmd_regs import qla_pkg::*; #(
    parameter int NUM_CHAN = DEF_NUM_CHAN
) (
    input  logic                  sysclk,
    input  logic                  arst_n,
    input  logic                  cmd_we,
    input  logic                  cmd_req,
    input  logic [3:0]            cmd_chan,     // 1..NUM_CHAN
    input  cmd_t                  wdata,
    input  logic                  dac_busy,
    output cmd_t [1:NUM_CHAN]     cur_cmd,
    output logic                  dac_update    // one cycle, dac latches commands
);

    logic cmd_pend;     // refresh requested, not yet handed to dac

    // --------------------
    // per-axis commands
    // --------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i <= NUM_CHAN; i++) begin
                cur_cmd[i] <= CMD_RESET;    // mid-scale, no current
            end
        end else begin
            for (int i = 1; i <= NUM_CHAN; i++) begin
                if (cmd_we && cmd_chan == 4'(i)) begin
                    cur_cmd[i] <= wdata;
                end
            end
        end
    end

    // --------------------
    // update handshake
    // --------------------
    // a request taken while busy just waits for busy to drop
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_pend   <= 1'b0;
            dac_update <= 1'b0;
        end else begin
            dac_update <= 1'b0;
            if (cmd_pend && !dac_busy) begin
                cmd_pend   <= 1'b0;     // a write this cycle is still latched
                dac_update <= 1'b1;
            end else if (cmd_req) begin
                cmd_pend <= 1'b1;
            end
        end
    end

    // serializer never gets a second load mid refresh
    a_update_idle: assert property (
        @(posedge sysclk) disable iff (!arst_n) dac_update |-> !dac_busy
    ) else $error("dac update while serializer busy");

endmodule

// File: motor/dac_serializer.sv
// --------------------
// serial dac refresh with one 24 bit frame per axis
// --------------------

module dac_serializer import qla_pkg::*; #(
    parameter int NUM_CHAN    = DEF_NUM_CHAN,
    parameter int DAC_CLK_DIV = DEF_DAC_CLK_DIV
) (
    input  logic                  sysclk,
    input  logic                  arst_n,
    input  logic                  dac_update,
    input  cmd_t [1:NUM_CHAN]     cur_cmd,
    output logic                  busy,
    output logic                  sclk,
    output logic                  mosi,
    output logic                  csel          // active low
);

    localparam int DIV_W = $clog2(DAC_CLK_DIV + 1);
    localparam int CH_W  = $clog2(NUM_CHAN + 2);       // must reach NUM_CHAN+1
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(DAC_CLK_DIV - 1);
    localparam logic [CH_W-1:0]  CH_END   = CH_W'(NUM_CHAN + 1);

    typedef enum logic [1:0] {S_IDLE, S_GAP, S_FRAME} state_t;

    state_t                   state;
    cmd_t [1:NUM_CHAN]        cmd_lat;      // snapshot for the whole refresh
    logic [DIV_W-1:0]         div_cnt;
    logic                     tick;         // sclk half period done
    logic [4:0]               bit_cnt;      // rising edges in a frame or ticks in a gap
    logic [CH_W-1:0]          chan;
    logic [DAC_FRAME_W-1:0]   shreg;

    assign tick = (div_cnt == DIV_LAST);

    // commands taken at the update pulse
    always_ff @(posedge sysclk) begin
        if (state == S_IDLE && dac_update) begin
            cmd_lat <= cur_cmd;
        end
    end

    // --------------------
    // frame/gap fsm
    // --------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= S_IDLE;
            busy    <= 1'b0;
            sclk    <= 1'b1;
            mosi    <= 1'b0;
            csel    <= 1'b1;
            div_cnt <= '0;
            bit_cnt <= '0;
            chan    <= '0;
            shreg   <= '0;
        end else begin
            div_cnt <= (state == S_IDLE || tick) ? '0 : div_cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    if (dac_update) begin
                        busy    <= 1'b1;
                        chan    <= CH_W'(1);
                        bit_cnt <= '0;
                        state   <= S_GAP;     // leading gap before chan 1
                    end
                end
                S_GAP: if (tick) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 5'd1) begin  // one full sclk period high
                        bit_cnt <= '0;
                        if (chan == CH_END) begin
                            busy  <= 1'b0;
                            state <= S_IDLE;
                        end else begin
                            shreg <= {DAC_CMD_WRITE_UPDATE, 4'(chan - 1'b1), cmd_lat[chan]};
                            csel  <= 1'b0;
                            state <= S_FRAME;
                        end
                    end
                end
                S_FRAME: if (tick) begin
                    if (bit_cnt == 5'(DAC_FRAME_W)) begin
                        csel    <= 1'b1;        // frame done while sclk is already high
                        mosi    <= 1'b0;
                        bit_cnt <= '0;
                        chan    <= chan + 1'b1;
                        state   <= S_GAP;
                    end else if (sclk) begin
                        sclk  <= 1'b0;          // falling edge puts out the next bit
                        mosi  <= shreg[DAC_FRAME_W-1];
                        shreg <= shreg << 1;
                    end else begin
                        sclk    <= 1'b1;        // rising edge where the dac samples
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // no chip select outside a refresh
    a_csel_idle: assert property (
        @(posedge sysclk) disable iff (!arst_n) !busy |-> csel
    ) else $error("dac csel low while idle");

endmodule

// File: motor/safety_check.sv
// --------------------
// per-axis overcurrent check, latched amp disable
// --------------------

module safety_check import qla_pkg::*; #(
    parameter int SAFETY_LIMIT = DEF_SAFETY_LIMIT
) (
    input  logic    sysclk,
    input  logic    arst_n,
    input  cmd_t    cur_fb,         // offset binary feedback
    input  cmd_t    cur_cmd,        // offset binary command
    input  logic    clear,          // pwr or amp enable for this axis
    output logic    amp_disable
);

    localparam int CNT_W = $clog2(SAFETY_LIMIT + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SAFETY_LIMIT - 1);

    cmd_t               fb_mag;
    cmd_t               cmd_mag;
    logic [17:0]        fb_limit;   // 2*|cmd| + margin, no overflow
    logic               bad;
    logic [CNT_W-1:0]   bad_cnt;    // consecutive bad samples

    // distance from mid-scale, either side
    assign fb_mag  = (cur_fb >= CMD_RESET) ? cur_fb - CMD_RESET : CMD_RESET - cur_fb;
    assign cmd_mag = (cur_cmd >= CMD_RESET) ? cur_cmd - CMD_RESET : CMD_RESET - cur_cmd;

    assign fb_limit = {1'b0, cmd_mag, 1'b0} + {2'b00, SAFETY_MARGIN};
    assign bad      = {2'b00, fb_mag} > fb_limit;

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            bad_cnt     <= '0;
            amp_disable <= 1'b0;
        end else if (clear) begin
            bad_cnt     <= '0;          // clear wins over a bad sample
            amp_disable <= 1'b0;
        end else if (!bad) begin
            bad_cnt <= '0;              // one good sample restarts the count
        end else begin
            if (bad_cnt == CNT_LAST) begin
                amp_disable <= 1'b1;    // stays set until clear
            end
            if (bad_cnt != CNT_LAST) begin
                bad_cnt <= bad_cnt + 1'b1;
            end
        end
    end

    // only an enable command may drop the disable
    a_latched: assert property (
        @(posedge sysclk) disable iff (!arst_n) $fell(amp_disable) |-> $past(clear)
    ) else $error("amp disable released without clear");

endmodule

// File: qla_motor_ctrl.f
common/qla_pkg.sv
logic/bus_ctrl.sv
motor/cur_cmd_regs.sv
motor/dac_serializer.sv
motor/safety_check.sv
logic/qla_motor_ctrl.sv
testbench/tb_qla_motor_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build and run the motor command path testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_qla_motor_ctrl \
    -f qla_motor_ctrl.f \
    -o tb_qla_motor_ctrl

./obj_dir/tb_qla_motor_ctrl

// File: testbench/qla_tests.txt
# op  W,T: blk addr data   R: addr expect   F: chan value   H: cycles   A: amp_disable mask
# D: frame count, then 24 bit frames {cmd, chan-1, code}   E: clear pulse, no operands
# reset values
R 0011 00008000
R 0021 00008000
R 0031 00008000
R 0041 00008000
A 0
# single write, channels 0 and 5 ignored, no refresh
W 0 0021 00001234
W 0 0001 0000abcd
W 0 0051 0000abcd
R 0021 00001234
R 0011 00008000
H 100
D 0
# host block write
W 0 0011 00009000
W 0 0021 00008400
W 0 0031 00007000
W 1 0041 0000c000
D 4 309000 318400 327000 33c000
# real-time block write, clashing host write ignored
T 0 11 00008100
T 0 21 00008200
T 0 31 00008300
T 1 41 00008400
D 4 308100 318200 328300 338400
R 0021 00008200
# overcurrent on ch2 below mid-scale, ch3 exactly at its limit
F 2 7aff
F 3 8700
H a
A 0
H a
A 2
R 002c 00008200
R 003c 10008300
F 2 8000
E
A 0
R 002c 10008200
# a good sample restarts the count
F 2 7aff
H 8
F 2 8000
F 2 7aff
H c
A 0
F 2 8000
# feedback readback and unmapped addresses
F 1 8123
R 0010 00008123
R 0015 00000000
R 1011 00000000

// File: testbench/tb_qla_motor_ctrl.sv
// --------------------
// testbench for the motor command path driven by a test file
// --------------------

module tb_qla_motor_ctrl import qla_pkg::*; ();

    localparam int NUM_CHAN        = 4;
    localparam int DAC_CLK_DIV     = 2;
    localparam int SAFETY_LIMIT    = 16;
    localparam int CLK_PERIOD      = 4;
    localparam int CYCLES_PER_LINE = 4000;     // watchdog budget per op

    logic               sysclk;
    logic               arst_n;
    host_wr_t           host_wr;
    rt_wr_t             rt_wr;
    addr_t              raddr;
    data_t              rdata;
    cmd_t [1:NUM_CHAN]  cur_fb;
    logic               pwr_enable_cmd;
    logic [NUM_CHAN:1]  amp_enable_cmd;
    logic               dac_sclk;
    logic               dac_mosi;
    logic               dac_csel;
    logic [NUM_CHAN:1]  amp_disable;

    // parsed test file with one entry per op
    logic [7:0]   op_q[$];
    logic [31:0]  a_q[$];
    logic [31:0]  b_q[$];
    logic [31:0]  c_q[$];
    logic [23:0]  exp_frames[$];    // all D lines in file order
    bit           parsed;

    // frames seen on the dac port
    logic [23:0]  got_frames[$];
    int           got_bits[$];
    logic [23:0]  frame_sr;
    int           frame_bits;

    qla_motor_ctrl #(
        .NUM_CHAN(NUM_CHAN), .DAC_CLK_DIV(DAC_CLK_DIV), .SAFETY_LIMIT(SAFETY_LIMIT)
    ) DUT (
        .sysclk(sysclk), .arst_n(arst_n),
        .host_wr(host_wr), .rt_wr(rt_wr),
        .raddr(raddr), .rdata(rdata),
        .cur_fb(cur_fb), .pwr_enable_cmd(pwr_enable_cmd), .amp_enable_cmd(amp_enable_cmd),
        .dac_sclk(dac_sclk), .dac_mosi(dac_mosi), .dac_csel(dac_csel),
        .amp_disable(amp_disable)
    );

    initial begin
        sysclk = 1'b0;
        forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
    end

    // --------------------
    // checks and failure
    // --------------------
    task automatic stop_run(input string why);
        $display("Verification failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, want);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // --------------------
    // test file
    // --------------------
    task automatic load_tests();
        int               fd;
        int               code;
        int               need;         // operands expected on this line
        logic [63:0]      tok;
        logic [8*128-1:0] rest;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        logic [31:0]      f;
        fd = $fopen("testbench/qla_tests.txt", "r");
        if (fd == 0) stop_run("cannot open testbench/qla_tests.txt");
        while ($fscanf(fd, "%s", tok) == 1) begin
            a = '0;
            b = '0;
            c = '0;
            need = 0;
            code = 0;
            case (tok[7:0])
                "#": code = $fgets(rest, fd);                   // comment line is skipped
                "W", "T": begin
                    need = 3;
                    code = $fscanf(fd, "%h %h %h", a, b, c);
                end
                "R", "F": begin
                    need = 2;
                    code = $fscanf(fd, "%h %h", a, b);
                end
                "H", "A", "D": begin
                    need = 1;
                    code = $fscanf(fd, "%h", a);
                end
                "E": need = 0;
                default: stop_run("unknown opcode in test file");
            endcase
            if (tok[7:0] != "#") begin
                if (code != need) stop_run("malformed line in test file");
                if (tok[7:0] == "D") begin
                    for (int i = 0; i < int'(a); i++) begin
                        if ($fscanf(fd, "%h", f) != 1) stop_run("missing dac frame in test file");
                        exp_frames.push_back(f[23:0]);
                    end
                end
                op_q.push_back(tok[7:0]);
                a_q.push_back(a);
                b_q.push_back(b);
                c_q.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    // --------------------
    // stimulus on falling edges
    // --------------------
    task automatic host_write(input logic blk, input logic [15:0] addr, input data_t data);
        @(negedge sysclk);
        host_wr.wen     = 1'b1;
        host_wr.blk_wen = blk;              // blk also requests a refresh
        host_wr.waddr   = addr_t'(addr);
        host_wr.wdata   = data;
        @(negedge sysclk);
        host_wr = '0;
    endtask

    // rt write with a clashing host write to the same register
    task automatic rt_write(input logic blk, input logic [7:0] waddr, input data_t data);
        @(negedge sysclk);
        rt_wr.active  = 1'b1;
        rt_wr.wen     = 1'b1;
        rt_wr.blk_wen = blk;
        rt_wr.waddr   = waddr;
        rt_wr.wdata   = data;
        host_wr.wen   = 1'b1;
        host_wr.waddr = addr_t'({ADDR_MAIN, 4'd0, waddr});
        host_wr.wdata = ~data;              // must lose
        @(negedge sysclk);
        rt_wr   = '0;
        host_wr = '0;
    endtask

    task automatic read_expect(input logic [15:0] addr, input data_t want);
        @(negedge sysclk);
        raddr = addr_t'(addr);
        @(posedge sysclk);                  // rdata settled since the falling edge
        check_value("rdata", rdata, want);
    endtask

    task automatic clear_pulse();
        @(negedge sysclk);
        pwr_enable_cmd = 1'b1;              // clears every axis
        @(negedge sysclk);
        pwr_enable_cmd = 1'b0;
    endtask

    // refresh done once csel has idled a full sclk period after the frames
    task automatic wait_refresh(input int count);
        int          quiet;
        logic [23:0] want;
        quiet = 0;
        while (got_frames.size() < count) begin
            @(negedge sysclk);
        end
        while (quiet < 2 * DAC_CLK_DIV + 2) begin
            @(negedge sysclk);
            quiet = dac_csel ? quiet + 1 : 0;
        end
        check_value("dac frame count", got_frames.size(), count);
        for (int i = 0; i < count; i++) begin
            want = exp_frames.pop_front();
            check_value("dac frame bits", got_bits[i], 24);
            check_value("dac frame", {8'd0, got_frames[i]}, {8'd0, want});
        end
        got_frames.delete();
        got_bits.delete();
    endtask

    // frame collector samples mosi at sclk rising
    always @(posedge dac_sclk) begin
        if (arst_n && dac_csel === 1'b0) begin
            frame_sr   = {frame_sr[22:0], dac_mosi};
            frame_bits = frame_bits + 1;
        end
    end

    always @(posedge dac_csel) begin
        if (frame_bits != 0) begin
            got_frames.push_back(frame_sr);
            got_bits.push_back(frame_bits);
            frame_bits = 0;
        end
    end

    initial begin : watchdog
        longint limit;
        wait (parsed);
        limit = longint'(op_q.size()) * CYCLES_PER_LINE * CLK_PERIOD;
        #(limit);
        stop_run("timeout, the test file did not finish in time");
    end

    // --------------------
    // main sequence
    // --------------------
    initial begin
        arst_n         = 1'b0;
        host_wr        = '0;
        rt_wr          = '0;
        raddr          = '0;
        cur_fb         = {NUM_CHAN{CMD_RESET}};     // zero current on every axis
        pwr_enable_cmd = 1'b0;
        amp_enable_cmd = '0;
        frame_sr       = '0;
        frame_bits     = 0;
        load_tests();
        parsed = 1'b1;
        repeat (2) @(negedge sysclk);
        arst_n = 1'b1;

        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "W": host_write(a_q[i][0], b_q[i][15:0], c_q[i]);
                "T": rt_write(a_q[i][0], b_q[i][7:0], c_q[i]);
                "R": read_expect(a_q[i][15:0], b_q[i]);
                "F": begin
                    @(negedge sysclk);
                    cur_fb[a_q[i]] = b_q[i][15:0];
                end
                "E": clear_pulse();
                "H": repeat (a_q[i]) @(negedge sysclk);
                "A": begin
                    @(negedge sysclk);
                    check_value("amp_disable", 32'(amp_disable), a_q[i]);
                end
                "D": wait_refresh(int'(a_q[i]));
                default: stop_run("unknown opcode while running");
            endcase
        end

        $display("Verification passed");
        $finish;
    end

endmodule
